// ==== Bender.yml ====
package:
  name: oflow_match

sources:
  - oflow_core_pkg.sv
  - oflow_similarity_pkg.sv
  - oflow_calc_iou.sv
  - oflow_similarity_metric.sv
  - oflow_history_buffer.sv
  - oflow_match_ctrl.sv
  - oflow_match_top.sv
  - target: test
    files:
      - oflow_match_tb.sv

// ==== oflow_calc_iou.sv ====
// intersection over union of two boxes, q0.10 result
// areas in one cycle, then a restoring divider at one quotient bit per cycle
// valid_iou pulses a fixed IOU_LATENCY cycles after start
`timescale 1ns/1ps

module oflow_calc_iou (
	input  logic clk,
	input  logic reset_N,
	input  logic start,
	input  logic [oflow_core_pkg::POSITION_LEN-1:0] position_a,
	input  logic [oflow_core_pkg::POSITION_LEN-1:0] position_b,
	input  logic [oflow_core_pkg::WIDTH_LEN-1:0] width_a,
	input  logic [oflow_core_pkg::HEIGHT_LEN-1:0] height_a,
	input  logic [oflow_core_pkg::WIDTH_LEN-1:0] width_b,
	input  logic [oflow_core_pkg::HEIGHT_LEN-1:0] height_b,
	output logic valid_iou,
	output logic [oflow_similarity_pkg::IOU_LEN-1:0] iou
);
	import oflow_core_pkg::*;
	import oflow_similarity_pkg::*;

	localparam int DIV_STEPS = IOU_LATENCY - 2;  // one quotient bit per cycle
	localparam int STEP_LEN  = $clog2(DIV_STEPS);
	localparam int AREA_LEN  = 2 * COORD_LEN;

	typedef enum logic [1:0] {idle_st, area_st, divide_st, done_st} state_t;
	state_t state;

	logic [COORD_LEN-1:0] ov_x, ov_y;               // overlap per axis
	logic [AREA_LEN-1:0] inter, area_a, area_b;
	logic [AREA_LEN:0] union_c;
	logic [AREA_LEN+FRAC_BITS-1:0] dividend;        // inter << FRAC_BITS

	logic [STEP_LEN-1:0] step;
	logic [AREA_LEN:0] rem, union_r;
	logic [DIV_STEPS-1:0] dvd_lo;                   // dividend bits still to shift in
	logic [IOU_LEN-1:0] quot;
	logic [AREA_LEN+1:0] trial;
	logic q_bit;

	// overlap of two intervals, clipped at zero
	function automatic logic [COORD_LEN-1:0] overlap(
		input logic [COORD_LEN-1:0] lo_a,
		input logic [COORD_LEN-1:0] hi_a,
		input logic [COORD_LEN-1:0] lo_b,
		input logic [COORD_LEN-1:0] hi_b
	);
		logic [COORD_LEN-1:0] lo;
		logic [COORD_LEN-1:0] hi;
		lo = (lo_a > lo_b) ? lo_a : lo_b;
		hi = (hi_a < hi_b) ? hi_a : hi_b;
		return (hi > lo) ? hi - lo : '0;
	endfunction

	// x uses tl_x/br_x, y uses tl_y/br_y
	assign ov_x = overlap(position_a[3*COORD_LEN +: COORD_LEN], position_a[COORD_LEN +: COORD_LEN],
		position_b[3*COORD_LEN +: COORD_LEN], position_b[COORD_LEN +: COORD_LEN]);
	assign ov_y = overlap(position_a[2*COORD_LEN +: COORD_LEN], position_a[0 +: COORD_LEN],
		position_b[2*COORD_LEN +: COORD_LEN], position_b[0 +: COORD_LEN]);

	assign inter    = ov_x * ov_y;
	assign area_a   = width_a * height_a;
	assign area_b   = width_b * height_b;
	assign union_c  = area_a + area_b - inter;
	assign dividend = {inter, {FRAC_BITS{1'b0}}};

	// one restoring step
	assign trial = {rem, dvd_lo[DIV_STEPS-1]};
	assign q_bit = (trial >= union_r);

	assign valid_iou = (state == done_st);

	// ------------------------------------------------------------
	// fsm
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= idle_st;
			step  <= '0;
		end else begin
			case (state)
				idle_st:   if (start) state <= area_st;
				area_st: begin
					step  <= '0;
					state <= divide_st;
				end
				divide_st: begin
					step <= step + 1'b1;
					if (step == STEP_LEN'(DIV_STEPS - 1)) state <= done_st;
				end
				default:   state <= idle_st;  // done_st, valid_iou high here
			endcase
		end
	end

	// divider datapath, no reset needed
	always_ff @(posedge clk) begin
		if (state == area_st) begin
			union_r <= union_c;
			rem     <= (AREA_LEN+1)'(dividend >> DIV_STEPS);  // high part, below union
			dvd_lo  <= dividend[DIV_STEPS-1:0];
			quot    <= '0;
		end else if (state == divide_st) begin
			rem    <= q_bit ? (AREA_LEN+1)'(trial - union_r) : trial[AREA_LEN:0];
			dvd_lo <= dvd_lo << 1;
			quot   <= {quot[IOU_LEN-2:0], q_bit};
			if (step == STEP_LEN'(DIV_STEPS - 1))
				iou <= (union_r == '0) ? '0 : {quot[IOU_LEN-2:0], q_bit};  // empty union gives 0
		end
	end

	a_iou_single_pulse: assert property (@(posedge clk) disable iff (!reset_N)
		valid_iou |=> !valid_iou);

endmodule

// ==== oflow_core_pkg.sv ====
// feature record of one tracked object, field widths and bit offsets
// imported by the history buffer, the metric and the top level
package oflow_core_pkg;

	// ------------------------------------------------------------
	// field widths
	// ------------------------------------------------------------
	localparam int COORD_LEN     = 8;              // one box coordinate
	localparam int POSITION_LEN  = 4 * COORD_LEN;  // {tl_x, tl_y, br_x, br_y}
	localparam int WIDTH_LEN     = 8;
	localparam int HEIGHT_LEN    = 8;
	localparam int COLOR_LEN     = 24;             // packed rgb
	localparam int D_HISTORY_LEN = 5;              // frames since last seen

	localparam int FEATURE_LEN = POSITION_LEN + WIDTH_LEN + HEIGHT_LEN
		+ 2 * COLOR_LEN + D_HISTORY_LEN;           // 101 bits

	// ------------------------------------------------------------
	// record layout, msb first
	// position, width, height, color1, color2, d_history
	// ------------------------------------------------------------
	localparam int D_HISTORY_LSB = 0;
	localparam int COLOR2_LSB    = D_HISTORY_LSB + D_HISTORY_LEN;
	localparam int COLOR1_LSB    = COLOR2_LSB + COLOR_LEN;
	localparam int HEIGHT_LSB    = COLOR1_LSB + COLOR_LEN;
	localparam int WIDTH_LSB     = HEIGHT_LSB + HEIGHT_LEN;
	localparam int POSITION_LSB  = WIDTH_LSB + WIDTH_LEN;

	localparam int DEFAULT_HISTORY_DEPTH = 8;  // entries kept from earlier frames

endpackage

// ==== oflow_history_buffer.sv ====
// feature records of objects from earlier frames, one valid bit each
// writes land on the next edge, reads are combinational
`timescale 1ns/1ps

module oflow_history_buffer #(
	parameter int HISTORY_DEPTH = oflow_core_pkg::DEFAULT_HISTORY_DEPTH
) (
	input  logic clk,
	input  logic reset_N,
	input  logic wr_en,
	input  logic clear,
	input  logic [$clog2(HISTORY_DEPTH)-1:0] wr_addr,
	input  logic [oflow_core_pkg::FEATURE_LEN-1:0] wr_features,
	input  logic [$clog2(HISTORY_DEPTH)-1:0] rd_addr,
	output logic [oflow_core_pkg::FEATURE_LEN-1:0] rd_features,
	output logic [HISTORY_DEPTH-1:0] entry_valid
);
	import oflow_core_pkg::*;

	logic [FEATURE_LEN-1:0] mem [HISTORY_DEPTH];

	assign rd_features = mem[rd_addr];

	// valid flags, clear beats a same-cycle write
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			entry_valid <= '0;
		else if (clear)
			entry_valid <= '0;
		else if (wr_en)
			entry_valid[wr_addr] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (wr_en && !clear)
			mem[wr_addr] <= wr_features;
	end

	a_wr_addr_range: assert property (@(posedge clk) disable iff (!reset_N)
		wr_en |-> wr_addr < HISTORY_DEPTH);

endmodule

// ==== oflow_match_ctrl.sv ====
// walks the valid history entries in ascending order, one metric run each
// keeps the lowest score and its index, lowest index wins a tie
`timescale 1ns/1ps

module oflow_match_ctrl #(
	parameter int HISTORY_DEPTH = oflow_core_pkg::DEFAULT_HISTORY_DEPTH
) (
	input  logic clk,
	input  logic reset_N,
	input  logic match_start,
	input  logic [HISTORY_DEPTH-1:0] entry_valid,
	output logic [$clog2(HISTORY_DEPTH)-1:0] rd_addr,
	output logic metric_start,
	input  logic metric_valid,
	input  logic [oflow_similarity_pkg::SCORE_LEN-1:0] metric_score,
	output logic busy,
	output logic done,
	output logic found,
	output logic [$clog2(HISTORY_DEPTH)-1:0] best_id,
	output logic [oflow_similarity_pkg::SCORE_LEN-1:0] best_score
);
	localparam int ID_LEN = $clog2(HISTORY_DEPTH);

	typedef enum logic [1:0] {idle_st, seek_st, wait_st, finish_st} state_t;
	state_t state;

	logic [HISTORY_DEPTH-1:0] pending;  // entries still to compare
	logic [ID_LEN-1:0] next_idx;

	// lowest pending index
	always_comb begin
		next_idx = '0;
		for (int i = HISTORY_DEPTH - 1; i >= 0; i--) begin
			if (pending[i])
				next_idx = ID_LEN'(i);
		end
	end

	assign busy = (state != idle_st);
	assign done = (state == finish_st);

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state        <= idle_st;
			pending      <= '0;
			rd_addr      <= '0;
			metric_start <= 1'b0;
			found        <= 1'b0;
			best_id      <= '0;
			best_score   <= '0;
		end else begin
			metric_start <= 1'b0;
			case (state)
				idle_st: if (match_start) begin
					pending    <= entry_valid;  // snapshot for this match
					found      <= 1'b0;
					best_id    <= '0;
					best_score <= '0;
					state      <= seek_st;
				end
				seek_st: if (|pending) begin
					rd_addr           <= next_idx;
					pending[next_idx] <= 1'b0;
					metric_start      <= 1'b1;  // rd_addr settles with it
					state             <= wait_st;
				end else begin
					state <= finish_st;
				end
				wait_st: if (metric_valid) begin
					if (!found || metric_score < best_score) begin  // strict, ties keep older
						found      <= 1'b1;
						best_id    <= rd_addr;
						best_score <= metric_score;
					end
					state <= seek_st;
				end
				default: state <= idle_st;  // finish_st, done pulse
			endcase
		end
	end

	a_done_single_pulse: assert property (@(posedge clk) disable iff (!reset_N)
		done |=> !done);

endmodule

// ==== oflow_match_input.txt ====
# clear | write addr tl_x tl_y br_x br_y width height color1 color2 d_history
# match tl_x tl_y br_x br_y width height color1 color2 w_iou w_w w_h w_c1 w_c2 w_dh found id score (hex)
# identical box, only the staleness penalty 3 * (1 << 4) is left
clear
write 0 0a 0a 1e 1e 14 14 102030 405060 4
match 0a 0a 1e 1e 14 14 102030 405060 05 07 09 02 04 03 1 0 00000030
# one distance at a time against entry 0
match 0a 0a 1e 1e 19 14 102030 405060 00 06 00 00 00 00 1 0 0000001e
match 0a 0a 1e 1e 14 0c 102030 405060 00 00 0b 00 00 00 1 0 00000058
match 0a 0a 1e 1e 14 14 102000 405060 00 00 00 0a 00 00 1 0 000001e0
match 0a 0a 1e 1e 14 14 102030 406060 00 00 00 00 03 00 1 0 00003000
# iou term, partial overlap (iou 146 and 614) and disjoint boxes
clear
write 0 00 00 14 14 14 14 000000 000000 0
match 0a 0a 1e 1e 14 14 000000 000000 c8 00 00 00 00 00 1 0 000000ab
match 05 00 19 14 14 14 000000 000000 ff 00 00 00 00 00 1 0 00000066
match 64 64 78 78 14 14 000000 000000 c8 00 00 00 00 00 1 0 000000c8
# entry 2 is cleared, 3 and 5 tie, lowest index wins
clear
write 2 0a 0a 1e 1e 14 14 808080 000000 0
clear
write 1 0a 0a 1e 1e 14 14 808090 000000 0
write 3 0a 0a 1e 1e 14 14 808085 000000 0
write 5 0a 0a 1e 1e 14 14 80807b 000000 0
write 6 0a 0a 1e 1e 14 14 808070 000000 0
match 0a 0a 1e 1e 14 14 808080 000000 00 00 00 01 00 00 1 3 00000005
write 0 0a 0a 1e 1e 14 14 808083 000000 0
match 0a 0a 1e 1e 14 14 808080 000000 00 00 00 01 00 00 1 0 00000003
# empty history
clear
match 0a 0a 1e 1e 14 14 000000 000000 01 01 01 01 01 01 0 0 00000000
# saturation from colours and from staleness
write 0 0a 0a 1e 1e 14 14 000000 000000 0
match 0a 0a 1e 1e 14 14 ffffff ffffff 00 00 00 ff ff 00 1 0 ffffffff
clear
write 4 0a 0a 1e 1e 14 14 000000 000000 1f
match 0a 0a 1e 1e 14 14 000000 000000 00 00 00 00 00 ff 1 4 ffffffff

// ==== oflow_match_tb.sv ====
// self-checking testbench for the object matcher
// runs the clear, write and match commands of oflow_match_input.txt in order
// and compares found, best_id and best_score with the values on each match line
`timescale 1ns/1ps

module oflow_match_tb;
	import oflow_core_pkg::*;
	import oflow_similarity_pkg::*;

	localparam int DEPTH  = DEFAULT_HISTORY_DEPTH;
	localparam int ID_LEN = $clog2(DEPTH);
	localparam STIM_FILE  = "oflow_match_input.txt";

	logic clk = 1'b0;
	logic reset_N;
	logic wr_en, clear, match_start;
	logic [ID_LEN-1:0] wr_addr;
	logic [FEATURE_LEN-1:0] wr_features;
	logic [POSITION_LEN-1:0] position_cur;
	logic [WIDTH_LEN-1:0] width_cur;
	logic [HEIGHT_LEN-1:0] height_cur;
	logic [COLOR_LEN-1:0] color1_cur, color2_cur;
	logic [WEIGHT_LEN-1:0] iou_weight, w_weight, h_weight;
	logic [WEIGHT_LEN-1:0] color1_weight, color2_weight, dhistory_weight;
	logic busy, done, found;
	logic [ID_LEN-1:0] best_id;
	logic [SCORE_LEN-1:0] best_score;

	int cycles = 0;
	int cycle_limit = 100000;      // replaced once the file is counted
	int test_count, pass_count, fail_count, line_no, fd;
	bit test_ok;
	string line;
	logic [31:0] fld [17];         // hex fields of the current line

	oflow_match_top #(.HISTORY_DEPTH(DEPTH)) i_oflow_match_top (
		.clk(clk), .reset_N(reset_N), .wr_en(wr_en), .clear(clear),
		.wr_addr(wr_addr), .wr_features(wr_features), .match_start(match_start),
		.position_cur(position_cur), .width_cur(width_cur), .height_cur(height_cur),
		.color1_cur(color1_cur), .color2_cur(color2_cur),
		.iou_weight(iou_weight), .w_weight(w_weight), .h_weight(h_weight),
		.color1_weight(color1_weight), .color2_weight(color2_weight),
		.dhistory_weight(dhistory_weight),
		.busy(busy), .done(done), .found(found), .best_id(best_id), .best_score(best_score)
	);

	always #4 clk = ~clk;  // 8 ns period

	// ------------------------------------------------------------
	// watchdog
	// ------------------------------------------------------------
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s: expected %h, got %h", name, expected, actual);
			test_ok = 1'b0;
		end
	endtask

	// budget: 30 + 20*depth per match + 2 per write
	task automatic count_commands();
		int cfd;
		int n_match;
		int n_write;
		string l;
		n_match = 0;
		n_write = 0;
		cfd = $fopen(STIM_FILE, "r");
		if (cfd != 0) begin
			while (!$feof(cfd)) begin
				if ($fgets(l, cfd) != 0) begin
					if (l[0] == "m") n_match++;
					else if (l[0] == "w") n_write++;
				end
			end
			$fclose(cfd);
		end
		cycle_limit = 30 + n_match * 20 * DEPTH + n_write * 2;
	endtask

	task automatic clear_history();
		clear = 1'b1;
		@(negedge clk);
		clear = 1'b0;
	endtask

	// fld: addr, tl_x, tl_y, br_x, br_y, width, height, color1, color2, d_history
	task automatic write_entry();
		wr_addr     = fld[0][ID_LEN-1:0];
		wr_features = {fld[1][7:0], fld[2][7:0], fld[3][7:0], fld[4][7:0],
			fld[5][WIDTH_LEN-1:0], fld[6][HEIGHT_LEN-1:0], fld[7][COLOR_LEN-1:0],
			fld[8][COLOR_LEN-1:0], fld[9][D_HISTORY_LEN-1:0]};
		wr_en = 1'b1;
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	// fld: box, size, colours, six weights, then found, best_id, best_score
	task automatic run_match();
		int waited;
		position_cur    = {fld[0][7:0], fld[1][7:0], fld[2][7:0], fld[3][7:0]};
		width_cur       = fld[4][WIDTH_LEN-1:0];
		height_cur      = fld[5][HEIGHT_LEN-1:0];
		color1_cur      = fld[6][COLOR_LEN-1:0];
		color2_cur      = fld[7][COLOR_LEN-1:0];
		iou_weight      = fld[8][WEIGHT_LEN-1:0];
		w_weight        = fld[9][WEIGHT_LEN-1:0];
		h_weight        = fld[10][WEIGHT_LEN-1:0];
		color1_weight   = fld[11][WEIGHT_LEN-1:0];
		color2_weight   = fld[12][WEIGHT_LEN-1:0];
		dhistory_weight = fld[13][WEIGHT_LEN-1:0];
		test_count++;
		test_ok = 1'b1;
		match_start = 1'b1;   // one-cycle strobe
		@(negedge clk);
		match_start = 1'b0;
		check_value("busy", 32'd1, 32'(busy));  // match accepted
		waited = 0;
		while (!done && waited < 20 * DEPTH) begin
			@(negedge clk);
			waited++;
		end
		if (!done) begin
			$display("test %0d: no done within %0d cycles of match_start", test_count, waited);
			test_ok = 1'b0;
		end else begin
			check_value("found", fld[14], 32'(found));
			check_value("best_id", fld[15], 32'(best_id));
			check_value("best_score", fld[16], best_score);
		end
		@(negedge clk);       // controller back in idle
		check_value("busy", 32'd0, 32'(busy));
		check_value("done", 32'd0, 32'(done));  // single pulse
		if (test_ok) pass_count++;
		else fail_count++;
		$display("test %0d (line %0d): %s", test_count, line_no, test_ok ? "ok" : "mismatch");
	endtask

	task automatic report_bad_line(input int n);
		$display("line %0d of the stimulus file is malformed, %0d fields read", line_no, n);
		fail_count++;
	endtask

	task automatic run_line();
		int n;
		case (line[0])
			"c": clear_history();
			"w": begin
				n = $sscanf(line, "write %h %h %h %h %h %h %h %h %h %h", fld[0], fld[1],
					fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8], fld[9]);
				if (n == 10) write_entry();
				else report_bad_line(n);
			end
			"m": begin
				n = $sscanf(line, "match %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8],
					fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15], fld[16]);
				if (n == 17) run_match();
				else report_bad_line(n);
			end
			default: ;  // comment or blank line
		endcase
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		reset_N = 1'b0;
		{wr_en, clear, match_start} = '0;
		wr_addr = '0;
		wr_features = '0;
		position_cur = '0;
		{width_cur, height_cur, color1_cur, color2_cur} = '0;
		{iou_weight, w_weight, h_weight} = '0;
		{color1_weight, color2_weight, dhistory_weight} = '0;
		test_count = 0;
		pass_count = 0;
		fail_count = 0;
		line_no = 0;
		count_commands();
		repeat (4) @(posedge clk);  // reset held 4 cycles
		@(negedge clk);
		reset_N = 1'b1;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file %s", STIM_FILE);
			fail_count++;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) != 0) begin
					line_no++;
					run_line();
				end
			end
			$fclose(fd);
		end
		$display("%0d tests run, %0d ok, %0d failing", test_count, pass_count, fail_count);
		if (fail_count == 0 && test_count > 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== oflow_match_top.sv ====
// matches one current object against the history of earlier frames
// host writes records, strobes match_start and waits for done
`timescale 1ns/1ps

module oflow_match_top #(
	parameter int HISTORY_DEPTH = oflow_core_pkg::DEFAULT_HISTORY_DEPTH
) (
	input  logic clk,
	input  logic reset_N,
	input  logic wr_en,
	input  logic clear,
	input  logic [$clog2(HISTORY_DEPTH)-1:0] wr_addr,
	input  logic [oflow_core_pkg::FEATURE_LEN-1:0] wr_features,
	input  logic match_start,
	input  logic [oflow_core_pkg::POSITION_LEN-1:0] position_cur,
	input  logic [oflow_core_pkg::WIDTH_LEN-1:0] width_cur,
	input  logic [oflow_core_pkg::HEIGHT_LEN-1:0] height_cur,
	input  logic [oflow_core_pkg::COLOR_LEN-1:0] color1_cur,
	input  logic [oflow_core_pkg::COLOR_LEN-1:0] color2_cur,
	input  logic [oflow_similarity_pkg::WEIGHT_LEN-1:0] iou_weight,
	input  logic [oflow_similarity_pkg::WEIGHT_LEN-1:0] w_weight,
	input  logic [oflow_similarity_pkg::WEIGHT_LEN-1:0] h_weight,
	input  logic [oflow_similarity_pkg::WEIGHT_LEN-1:0] color1_weight,
	input  logic [oflow_similarity_pkg::WEIGHT_LEN-1:0] color2_weight,
	input  logic [oflow_similarity_pkg::WEIGHT_LEN-1:0] dhistory_weight,
	output logic busy,
	output logic done,
	output logic found,
	output logic [$clog2(HISTORY_DEPTH)-1:0] best_id,
	output logic [oflow_similarity_pkg::SCORE_LEN-1:0] best_score
);
	import oflow_core_pkg::*;
	import oflow_similarity_pkg::*;

	logic [$clog2(HISTORY_DEPTH)-1:0] rd_addr;
	logic [FEATURE_LEN-1:0] rd_features;
	logic [HISTORY_DEPTH-1:0] entry_valid;
	logic metric_start, metric_valid;
	logic [SCORE_LEN-1:0] metric_score;

	oflow_history_buffer #(.HISTORY_DEPTH(HISTORY_DEPTH)) i_oflow_history_buffer (
		.clk(clk), .reset_N(reset_N), .wr_en(wr_en), .clear(clear),
		.wr_addr(wr_addr), .wr_features(wr_features),
		.rd_addr(rd_addr), .rd_features(rd_features), .entry_valid(entry_valid)
	);

	oflow_match_ctrl #(.HISTORY_DEPTH(HISTORY_DEPTH)) i_oflow_match_ctrl (
		.clk(clk), .reset_N(reset_N), .match_start(match_start),
		.entry_valid(entry_valid), .rd_addr(rd_addr), .metric_start(metric_start),
		.metric_valid(metric_valid), .metric_score(metric_score),
		.busy(busy), .done(done), .found(found), .best_id(best_id), .best_score(best_score)
	);

	oflow_similarity_metric i_oflow_similarity_metric (
		.clk(clk), .reset_N(reset_N), .start(metric_start),
		.position_cur(position_cur), .width_cur(width_cur), .height_cur(height_cur),
		.color1_cur(color1_cur), .color2_cur(color2_cur), .features_prev(rd_features),
		.iou_weight(iou_weight), .w_weight(w_weight), .h_weight(h_weight),
		.color1_weight(color1_weight), .color2_weight(color2_weight),
		.dhistory_weight(dhistory_weight),
		.valid(metric_valid), .score(metric_score)
	);

	// history must not change under a running match
	a_no_write_while_busy: assert property (@(posedge clk) disable iff (!reset_N)
		busy |-> !wr_en);

endmodule

// ==== oflow_similarity_metric.sv ====
// weighted distance between the current object and one history record
// lower score means more alike, valid pulses 15 cycles after start
`timescale 1ns/1ps

module oflow_similarity_metric (
	input  logic clk,
	input  logic reset_N,
	input  logic start,
	input  logic [oflow_core_pkg::POSITION_LEN-1:0] position_cur,
	input  logic [oflow_core_pkg::WIDTH_LEN-1:0] width_cur,
	input  logic [oflow_core_pkg::HEIGHT_LEN-1:0] height_cur,
	input  logic [oflow_core_pkg::COLOR_LEN-1:0] color1_cur,
	input  logic [oflow_core_pkg::COLOR_LEN-1:0] color2_cur,
	input  logic [oflow_core_pkg::FEATURE_LEN-1:0] features_prev,
	input  logic [oflow_similarity_pkg::WEIGHT_LEN-1:0] iou_weight,
	input  logic [oflow_similarity_pkg::WEIGHT_LEN-1:0] w_weight,
	input  logic [oflow_similarity_pkg::WEIGHT_LEN-1:0] h_weight,
	input  logic [oflow_similarity_pkg::WEIGHT_LEN-1:0] color1_weight,
	input  logic [oflow_similarity_pkg::WEIGHT_LEN-1:0] color2_weight,
	input  logic [oflow_similarity_pkg::WEIGHT_LEN-1:0] dhistory_weight,
	output logic valid,
	output logic [oflow_similarity_pkg::SCORE_LEN-1:0] score
);
	import oflow_core_pkg::*;
	import oflow_similarity_pkg::*;

	localparam int STALE_LEN = 2 ** D_HISTORY_LEN;  // 1 << d_history
	localparam int ACC_LEN   = SUM_LEN + 2;         // staleness term alone can pass 2^48

	typedef enum logic [1:0] {idle_st, calc_st, sum_st} state_t;
	state_t state;

	// previous record fields
	logic [POSITION_LEN-1:0] position_prev;
	logic [WIDTH_LEN-1:0] width_prev;
	logic [HEIGHT_LEN-1:0] height_prev;
	logic [COLOR_LEN-1:0] color1_prev, color2_prev;
	logic [D_HISTORY_LEN-1:0] d_history_prev;

	logic start_iou, valid_iou;
	logic [IOU_LEN-1:0] iou;

	// registered metrics, integer parts except iou_term (q0.10)
	logic [IOU_LEN-1:0] iou_term;
	logic [WIDTH_LEN-1:0] w_dist;
	logic [HEIGHT_LEN-1:0] h_dist;
	logic [COLOR_LEN-1:0] c1_dist, c2_dist;
	logic [STALE_LEN-1:0] stale;

	logic [ACC_LEN-1:0] sum_full;
	logic [SUM_LEN-1:0] sum_r;

	function automatic logic [COLOR_LEN-1:0] l1_dist(
		input logic [COLOR_LEN-1:0] a,
		input logic [COLOR_LEN-1:0] b
	);
		return (a > b) ? a - b : b - a;
	endfunction

	assign position_prev  = features_prev[POSITION_LSB +: POSITION_LEN];
	assign width_prev     = features_prev[WIDTH_LSB +: WIDTH_LEN];
	assign height_prev    = features_prev[HEIGHT_LSB +: HEIGHT_LEN];
	assign color1_prev    = features_prev[COLOR1_LSB +: COLOR_LEN];
	assign color2_prev    = features_prev[COLOR2_LSB +: COLOR_LEN];
	assign d_history_prev = features_prev[D_HISTORY_LSB +: D_HISTORY_LEN];

	assign start_iou = (state == idle_st) && start;  // leaving idle

	oflow_calc_iou i_oflow_calc_iou (
		.clk       (clk),
		.reset_N   (reset_N),
		.start     (start_iou),
		.position_a(position_cur),
		.position_b(position_prev),
		.width_a   (width_cur),
		.height_a  (height_cur),
		.width_b   (width_prev),
		.height_b  (height_prev),
		.valid_iou (valid_iou),
		.iou       (iou)
	);

	// ------------------------------------------------------------
	// weighted sum, each term padded to q.10
	// ------------------------------------------------------------
	assign sum_full = iou_weight * iou_term
		+ w_weight * {w_dist, {FRAC_BITS{1'b0}}}
		+ h_weight * {h_dist, {FRAC_BITS{1'b0}}}
		+ color1_weight * {c1_dist, {FRAC_BITS{1'b0}}}
		+ color2_weight * {c2_dist, {FRAC_BITS{1'b0}}}
		+ dhistory_weight * {stale, {FRAC_BITS{1'b0}}};

	// integer part, saturated to the score width
	assign score = (|sum_r[SUM_LEN-1:FRAC_BITS+SCORE_LEN]) ? '1 : sum_r[FRAC_BITS +: SCORE_LEN];

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= idle_st;
			valid <= 1'b0;
		end else begin
			valid <= (state == sum_st);  // one cycle after the sum
			case (state)
				idle_st: if (start) state <= calc_st;
				calc_st: if (valid_iou) state <= sum_st;
				default: state <= idle_st;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == calc_st) begin
			w_dist  <= WIDTH_LEN'(l1_dist(COLOR_LEN'(width_prev), COLOR_LEN'(width_cur)));
			h_dist  <= HEIGHT_LEN'(l1_dist(COLOR_LEN'(height_prev), COLOR_LEN'(height_cur)));
			c1_dist <= l1_dist(color1_prev, color1_cur);
			c2_dist <= l1_dist(color2_prev, color2_cur);
			stale   <= STALE_LEN'(1) << d_history_prev;  // staleness penalty
			if (valid_iou)
				iou_term <= IOU_LEN'(1 << FRAC_BITS) - iou;  // 1 - iou
		end
		if (state == sum_st)
			sum_r <= (|sum_full[ACC_LEN-1:SUM_LEN]) ? '1 : sum_full[SUM_LEN-1:0];
	end

	a_start_in_idle: assert property (@(posedge clk) disable iff (!reset_N)
		start |-> state == idle_st);

endmodule

// ==== oflow_similarity_pkg.sv ====
// widths of the similarity datapath, q.10 fixed point
// imported by the metric, the iou block, the controller and the top level
package oflow_similarity_pkg;

	localparam int FRAC_BITS = 10;             // fraction bits of every metric

	// iou in q0.10, one extra bit so 1.0 fits exactly
	localparam int IOU_LEN = FRAC_BITS + 1;

	localparam int WEIGHT_LEN = 8;             // host weight per term
	localparam int SUM_LEN    = 48;            // weighted sum, q38.10
	localparam int SCORE_LEN  = 32;            // saturated integer part

	// start -> valid_iou
	// one area cycle, one divide cycle per quotient bit, one done cycle
	localparam int IOU_LATENCY = IOU_LEN + 2;  // 13

endpackage

// ==== verilog.f ====
oflow_core_pkg.sv
oflow_similarity_pkg.sv
oflow_calc_iou.sv
oflow_similarity_metric.sv
oflow_history_buffer.sv
oflow_match_ctrl.sv
oflow_match_top.sv
oflow_match_tb.sv
